// File: Makefile
SIM := obj_dir/Vtb_eye_tracker

.PHONY: all run clean

all: run

$(SIM): src.f $(wildcard common/*.sv common/*.svh hdl/*.sv gravity/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f src.f --top-module tb_eye_tracker -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/eye_tracker_pkg.sv
/* Types shared by the eye tracker RTL.
   Each module takes them with a wildcard import in its header. */
`include "eye_tracker_settings.svh"

package eye_tracker_pkg;

    // one camera sample
    typedef logic [`ET_PIXEL_W-1:0]    pixel_t;

    // column or row index inside a frame
    typedef logic [`ET_COORD_W-1:0]    coord_t;

    // number of bright pixels in a frame
    typedef logic [`ET_SUM_S_W-1:0]    sum_s_t;

    // first moment, also dividend and quotient of the divider
    typedef logic [`ET_SUM_M_W-1:0]    sum_m_t;

    // wishbone bus words
    typedef logic [`ET_WB_ADDR_W-1:0]  wb_addr_t;
    typedef logic [`ET_WB_DATA_W-1:0]  wb_data_t;

    // divider sequencing
    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_t;

endpackage

// File: common/eye_tracker_settings.svh
/* Widths, test frame limits and the Wishbone register map of the eye tracker.
   Included by the package, the RTL that needs a macro and the testbench. */
`ifndef EYE_TRACKER_SETTINGS_SVH
`define EYE_TRACKER_SETTINGS_SVH

// data path widths
`define ET_PIXEL_W      8
`define ET_COORD_W      10
`define ET_SUM_S_W      20
`define ET_SUM_M_W      28
`define ET_WB_ADDR_W    4
`define ET_WB_DATA_W    32

// test frame geometry and threshold after reset
`define ET_FRAME_W      32
`define ET_FRAME_H      24
`define ET_THRESH_INIT  8'd128

// wishbone word addresses
`define ET_REG_CTRL     4'd0
`define ET_REG_THRESH   4'd1
`define ET_REG_STATUS   4'd2
`define ET_REG_FRAMES   4'd3
`define ET_REG_SUM_S    4'd4
`define ET_REG_SUM_SX   4'd5
`define ET_REG_SUM_SY   4'd6
`define ET_REG_POINT_X  4'd7
`define ET_REG_POINT_Y  4'd8

`endif

// File: gravity/gravity_accum.sv
/* Binarizes the pixel stream against the threshold and accumulates the count
   and the x and y first moments of the bright pixels over one frame.
   The totals are held and flagged by sums_valid one cycle after frame_end. */
`timescale 1ns/1ps

module gravity_accum
    import eye_tracker_pkg::*;
(
    input  logic   cclk,
    input  logic   rst,
    input  logic   pix_valid,
    input  logic   frame_start,
    input  logic   frame_end,
    input  coord_t pix_x,
    input  coord_t pix_y,
    input  pixel_t pix_data,
    input  pixel_t threshold,
    input  logic   enable,
    output logic   sums_valid,
    output sum_s_t sum_s,
    output sum_m_t sum_sx,
    output sum_m_t sum_sy
);
    logic   bright;
    // running sums
    sum_s_t acc_s;
    sum_m_t acc_sx;
    sum_m_t acc_sy;
    // running sums, cleared when the frame starts
    sum_s_t base_s;
    sum_m_t base_sx;
    sum_m_t base_sy;

    assign bright = pix_valid & enable & (pix_data >= threshold);

    always_comb begin
        base_s  = frame_start ? '0 : acc_s;
        base_sx = frame_start ? '0 : acc_sx;
        base_sy = frame_start ? '0 : acc_sy;
    end

    // ------------------------------
    // accumulation
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            acc_s  <= '0;
            acc_sx <= '0;
            acc_sy <= '0;
        end else if (bright) begin
            acc_s  <= base_s + 1'b1;
            acc_sx <= base_sx + sum_m_t'(pix_x);
            acc_sy <= base_sy + sum_m_t'(pix_y);
        end else begin
            acc_s  <= base_s;
            acc_sx <= base_sx;
            acc_sy <= base_sy;
        end
    end

    // frame totals, stable until the next frame ends
    always_ff @(posedge cclk) begin
        if (rst) begin
            sums_valid <= 1'b0;
            sum_s      <= '0;
            sum_sx     <= '0;
            sum_sy     <= '0;
        end else begin
            sums_valid <= frame_end;
            if (frame_end) begin
                sum_s  <= acc_s;
                sum_sx <= acc_sx;
                sum_sy <= acc_sy;
            end
        end
    end

endmodule

// File: gravity/gravity_divider.sv
/* Restoring shift-subtract divider for one gravity coordinate.
   start is taken in idle only; done pulses 29 cycles later with the
   quotient rounded down. A zero divisor yields a zero quotient. */
`timescale 1ns/1ps
`include "eye_tracker_settings.svh"

module gravity_divider
    import eye_tracker_pkg::*;
(
    input  logic   cclk,
    input  logic   rst,
    input  logic   start,
    input  sum_m_t dividend,
    input  sum_s_t divisor,
    output sum_m_t quotient,
    output logic   done
);
    div_state_t state;
    logic [$clog2(`ET_SUM_M_W)-1:0] bit_cnt;

    // dividend bits shift out on the left, quotient bits in on the right
    sum_m_t quo;
    sum_s_t rem;
    sum_s_t dvs;

    // one extra bit for the borrow
    logic [`ET_SUM_S_W:0] trial;
    logic [`ET_SUM_S_W:0] diff;
    logic                 take;

    assign trial = {rem, quo[`ET_SUM_M_W-1]};
    assign diff  = trial - {1'b0, dvs};
    assign take  = ~diff[`ET_SUM_S_W] & (dvs != '0);

    // ------------------------------
    // sequencing
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            state   <= div_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                div_idle: begin
                    bit_cnt <= '0;
                    if (start) begin
                        state <= div_run;
                    end
                end
                div_run: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // last quotient bit
                    if (bit_cnt == ($clog2(`ET_SUM_M_W))'(`ET_SUM_M_W - 1)) begin
                        state <= div_done;
                    end
                end
                default: begin
                    state <= div_idle;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge cclk) begin
        if (state == div_idle && start) begin
            quo <= dividend;
            rem <= '0;
            dvs <= divisor;
        end else if (state == div_run) begin
            quo <= {quo[`ET_SUM_M_W-2:0], take};
            rem <= take ? diff[`ET_SUM_S_W-1:0] : trial[`ET_SUM_S_W-1:0];
        end
    end

    assign quotient = quo;
    assign done     = (state == div_done);

endmodule

// File: hdl/camera_input.sv
/* Camera Link style input stage. Samples fval, lval, dval and the pixel lane,
   then gives pixel valid with its column and row plus frame start and end
   pulses, all two cycles after the pins. */
`timescale 1ns/1ps

module camera_input
    import eye_tracker_pkg::*;
(
    input  logic   cclk,
    input  logic   rst,
    input  logic   fval,
    input  logic   lval,
    input  logic   dval,
    input  pixel_t data,
    output logic   pix_valid,
    output coord_t pix_x,
    output coord_t pix_y,
    output pixel_t pix_data,
    output logic   frame_start,
    output logic   frame_end
);
    // first register stage on the pins
    logic   fval_q1;
    logic   lval_q1;
    logic   dval_q1;
    pixel_t data_q1;
    // previous strobes, for the edges
    logic   fval_q2;
    logic   lval_q2;

    logic   frame_rise;
    logic   frame_fall;
    logic   line_rise;
    logic   line_fall;
    logic   valid_q1;
    coord_t col_cnt;
    coord_t row_cnt;
    coord_t col_now;
    coord_t row_now;

    always_ff @(posedge cclk) begin
        if (rst) begin
            fval_q1 <= 1'b0;
            lval_q1 <= 1'b0;
            dval_q1 <= 1'b0;
            fval_q2 <= 1'b0;
            lval_q2 <= 1'b0;
        end else begin
            fval_q1 <= fval;
            lval_q1 <= lval;
            dval_q1 <= dval;
            fval_q2 <= fval_q1;
            lval_q2 <= lval_q1;
        end
    end

    always_ff @(posedge cclk) begin
        data_q1 <= data;
    end

    assign frame_rise = fval_q1 & ~fval_q2;
    assign frame_fall = ~fval_q1 & fval_q2;
    assign line_rise  = lval_q1 & ~lval_q2;
    assign line_fall  = ~lval_q1 & lval_q2;
    assign valid_q1   = fval_q1 & lval_q1 & dval_q1;

    // counters restart on the edge itself so the first pixel gets index 0
    assign col_now = line_rise ? '0 : col_cnt;
    assign row_now = frame_rise ? '0 : row_cnt;

    // ------------------------------
    // column and row counters
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            col_cnt <= valid_q1 ? col_now + 1'b1 : col_now;
            row_cnt <= line_fall ? row_now + 1'b1 : row_now;
        end
    end

    // second stage, outputs
    always_ff @(posedge cclk) begin
        if (rst) begin
            pix_valid   <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            pix_valid   <= valid_q1;
            frame_start <= frame_rise;
            frame_end   <= frame_fall;
        end
    end

    always_ff @(posedge cclk) begin
        pix_x    <= col_now;
        pix_y    <= row_now;
        pix_data <= data_q1;
    end

endmodule

// File: hdl/eye_tracker_regs.sv
/* Wishbone classic slave register bank of the eye tracker.
   Holds threshold and enable, counts frames and latches the sums and the
   gravity point when a result arrives. One ack per access, no wait states. */
`timescale 1ns/1ps
`include "eye_tracker_settings.svh"

module eye_tracker_regs
    import eye_tracker_pkg::*;
(
    input  logic     cclk,
    input  logic     rst,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    input  logic     sums_valid,
    input  logic     result_valid,
    input  sum_s_t   sum_s,
    input  sum_m_t   sum_sx,
    input  sum_m_t   sum_sy,
    input  sum_m_t   point_x,
    input  sum_m_t   point_y,
    output pixel_t   threshold,
    output logic     enable
);
    logic     req;
    logic     ready;
    wb_data_t frame_cnt;
    wb_data_t rd_mux;
    // results as seen by the host
    sum_s_t   lat_s;
    sum_m_t   lat_sx;
    sum_m_t   lat_sy;
    sum_m_t   lat_px;
    sum_m_t   lat_py;

    // new access, ack not yet given
    assign req = wb_cyc & wb_stb & ~wb_ack;

    always_comb begin
        case (wb_adr)
            `ET_REG_CTRL:    rd_mux = wb_data_t'(enable);
            `ET_REG_THRESH:  rd_mux = wb_data_t'(threshold);
            `ET_REG_STATUS:  rd_mux = wb_data_t'(ready);
            `ET_REG_FRAMES:  rd_mux = frame_cnt;
            `ET_REG_SUM_S:   rd_mux = wb_data_t'(lat_s);
            `ET_REG_SUM_SX:  rd_mux = wb_data_t'(lat_sx);
            `ET_REG_SUM_SY:  rd_mux = wb_data_t'(lat_sy);
            `ET_REG_POINT_X: rd_mux = wb_data_t'(lat_px);
            `ET_REG_POINT_Y: rd_mux = wb_data_t'(lat_py);
            default:         rd_mux = '0;
        endcase
    end

    // ------------------------------
    // bus handshake and control
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            enable    <= 1'b1;
            threshold <= `ET_THRESH_INIT;
        end else begin
            wb_ack <= req;
            if (req && wb_we && wb_adr == `ET_REG_CTRL) begin
                enable <= wb_dat_w[0];
            end
            if (req && wb_we && wb_adr == `ET_REG_THRESH) begin
                threshold <= wb_dat_w[`ET_PIXEL_W-1:0];
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

    // ------------------------------
    // status and results
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            ready     <= 1'b0;
            frame_cnt <= '0;
            lat_s     <= '0;
            lat_sx    <= '0;
            lat_sy    <= '0;
            lat_px    <= '0;
            lat_py    <= '0;
        end else begin
            if (sums_valid) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            // a new result wins over a clearing read
            if (result_valid) begin
                ready  <= 1'b1;
                lat_s  <= sum_s;
                lat_sx <= sum_sx;
                lat_sy <= sum_sy;
                lat_px <= point_x;
                lat_py <= point_y;
            end else if (req && !wb_we && wb_adr == `ET_REG_STATUS) begin
                ready <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/eye_tracker_top.sv
/* Top level of the eye tracker measurement path on the camera clock.
   Camera input feeds the moment accumulator, two dividers find the
   gravity point and the Wishbone register bank exposes the results. */
`timescale 1ns/1ps

module eye_tracker_top
    import eye_tracker_pkg::*;
(
    input  logic     cclk,
    input  logic     rst,
    // camera pins
    input  logic     fval,
    input  logic     lval,
    input  logic     dval,
    input  pixel_t   data,
    // wishbone slave
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack
);
    logic   pix_valid;
    coord_t pix_x;
    coord_t pix_y;
    pixel_t pix_data;
    logic   frame_start;
    logic   frame_end;

    pixel_t threshold;
    logic   enable;

    logic   sums_valid;
    sum_s_t sum_s;
    sum_m_t sum_sx;
    sum_m_t sum_sy;

    sum_m_t point_x;
    sum_m_t point_y;
    logic   done_x;
    logic   done_y;
    logic   result_valid;

    camera_input u_camera_input (
        .cclk        (cclk),
        .rst         (rst),
        .fval        (fval),
        .lval        (lval),
        .dval        (dval),
        .data        (data),
        .pix_valid   (pix_valid),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_data    (pix_data),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    gravity_accum u_gravity_accum (
        .cclk        (cclk),
        .rst         (rst),
        .pix_valid   (pix_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_data    (pix_data),
        .threshold   (threshold),
        .enable      (enable),
        .sums_valid  (sums_valid),
        .sum_s       (sum_s),
        .sum_sx      (sum_sx),
        .sum_sy      (sum_sy)
    );

    // ------------------------------
    // gravity point, x and y in step
    // ------------------------------
    gravity_divider div_x (
        .cclk     (cclk),
        .rst      (rst),
        .start    (sums_valid),
        .dividend (sum_sx),
        .divisor  (sum_s),
        .quotient (point_x),
        .done     (done_x)
    );

    gravity_divider div_y (
        .cclk     (cclk),
        .rst      (rst),
        .start    (sums_valid),
        .dividend (sum_sy),
        .divisor  (sum_s),
        .quotient (point_y),
        .done     (done_y)
    );

    // both dividers finish in the same cycle
    assign result_valid = done_x & done_y;

    eye_tracker_regs u_eye_tracker_regs (
        .cclk         (cclk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .sums_valid   (sums_valid),
        .result_valid (result_valid),
        .sum_s        (sum_s),
        .sum_sx       (sum_sx),
        .sum_sy       (sum_sy),
        .point_x      (point_x),
        .point_y      (point_y),
        .threshold    (threshold),
        .enable       (enable)
    );

endmodule

// File: src.f
+incdir+common
common/eye_tracker_pkg.sv
hdl/camera_input.sv
gravity/gravity_accum.sv
gravity/gravity_divider.sv
hdl/eye_tracker_regs.sv
hdl/eye_tracker_top.sv
testbench/eye_tracker_assertions.sv
testbench/tb_checker.sv
testbench/tb_eye_tracker.sv

// File: testbench/eye_tracker_assertions.sv
/* Protocol checks bound into the eye tracker top. Wishbone ack is single
   cycle and only answers a request, the dividers finish together. */
`timescale 1ns/1ps

module eye_tracker_assertions (
    input logic cclk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic done_x,
    input logic done_y
);
    int fail_count = 0;

    ack_single: assert property (@(posedge cclk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $error("Wishbone ack held for two cycles");
            fail_count++;
        end

    ack_after_stb: assert property (@(posedge cclk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("Wishbone ack without a strobe in the cycle before");
            fail_count++;
        end

    // every new request is answered in the next cycle
    req_acked: assert property (@(posedge cclk) disable iff (rst)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            $error("Wishbone request not acked in the next cycle");
            fail_count++;
        end

    done_in_step: assert property (@(posedge cclk) disable iff (rst) done_x == done_y)
        else begin
            $error("x and y dividers finished in different cycles");
            fail_count++;
        end

    done_pulse: assert property (@(posedge cclk) disable iff (rst) done_x |=> !done_x)
        else begin
            $error("divider done longer than one cycle");
            fail_count++;
        end

endmodule

// File: testbench/eye_tracker_vectors.txt
# name threshold enable level x0 y0 w h, all numbers decimal
# level is the pixel value inside the rectangle, the frame is 32 by 24
centre 128 1 255 12 8 6 5
corner 100 1 255 0 0 4 3
far_corner 200 1 255 26 19 6 5
single 64 1 255 17 11 1 1
wide_strip 150 1 255 0 10 32 2
disabled 128 0 255 10 6 8 8
level_254 255 1 254 5 5 10 10
full_frame 1 1 255 0 0 32 24
thresh_equal 180 1 180 3 14 9 7
tall 90 1 255 30 0 2 24

// File: testbench/tb_checker.sv
/* Watches the camera pins and the Wishbone bus of the DUT. Builds the
   expected register bank from the pins and compares every read. */
`timescale 1ns/1ps
`include "eye_tracker_settings.svh"

module tb_checker
    import eye_tracker_pkg::*;
(
    input  logic            cclk,
    input  logic            rst,
    input  logic            fval,
    input  logic            lval,
    input  logic            dval,
    input  pixel_t          data,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  wb_addr_t        wb_adr,
    input  wb_data_t        wb_dat_w,
    input  wb_data_t        wb_dat_r,
    input  logic            wb_ack,
    input  logic [8*16-1:0] test_name,
    output int              error_count
);
    int errors = 0;

    // register bank as the host should see it
    logic     m_enable;
    pixel_t   m_thresh;
    logic     m_ready;
    wb_data_t m_frames;
    wb_data_t m_sum_s;
    wb_data_t m_sum_sx;
    wb_data_t m_sum_sy;
    wb_data_t m_point_x;
    wb_data_t m_point_y;

    // frame on the pins
    wb_data_t run_s;
    wb_data_t run_sx;
    wb_data_t run_sy;
    wb_data_t end_s;
    wb_data_t end_sx;
    wb_data_t end_sy;
    int       col;
    int       row;
    int       since_fall;
    logic     fval_d;
    logic     lval_d;

    // access waiting for its ack
    logic     pending;
    logic     pend_we;
    wb_addr_t pend_adr;
    wb_data_t pend_exp;

    assign error_count = errors;

    function automatic wb_data_t expected_read(input wb_addr_t adr);
        case (adr)
            `ET_REG_CTRL:    return wb_data_t'(m_enable);
            `ET_REG_THRESH:  return wb_data_t'(m_thresh);
            `ET_REG_STATUS:  return wb_data_t'(m_ready);
            `ET_REG_FRAMES:  return m_frames;
            `ET_REG_SUM_S:   return m_sum_s;
            `ET_REG_SUM_SX:  return m_sum_sx;
            `ET_REG_SUM_SY:  return m_sum_sy;
            `ET_REG_POINT_X: return m_point_x;
            `ET_REG_POINT_Y: return m_point_y;
            default:         return '0;
        endcase
    endfunction

    always @(posedge cclk) begin
        if (rst) begin
            m_enable   = 1'b1;
            m_thresh   = `ET_THRESH_INIT;
            m_ready    = 1'b0;
            m_frames   = '0;
            m_sum_s    = '0;
            m_sum_sx   = '0;
            m_sum_sy   = '0;
            m_point_x  = '0;
            m_point_y  = '0;
            since_fall = 0;
            fval_d     = 1'b0;
            lval_d     = 1'b0;
            pending    = 1'b0;
        end else begin
            // ------------------------------
            // bus side
            // ------------------------------
            if (wb_ack) begin
                if (!pending) begin
                    $display("ack seen with no access pending, address %0d", wb_adr);
                    errors++;
                end else if (!pend_we && wb_dat_r != pend_exp) begin
                    $display("Error %0s: register %0d expected %0d actual %0d",
                             test_name, pend_adr, pend_exp, wb_dat_r);
                    errors++;
                end
                pending = 1'b0;
            end else if (pending) begin
                $display("access to address %0d got no ack", pend_adr);
                errors++;
                pending = 1'b0;
            end

            if (wb_cyc && wb_stb && !wb_ack) begin
                pending  = 1'b1;
                pend_we  = wb_we;
                pend_adr = wb_adr;
                pend_exp = expected_read(wb_adr);
                if (wb_we && wb_adr == `ET_REG_CTRL) begin
                    m_enable = wb_dat_w[0];
                end else if (wb_we && wb_adr == `ET_REG_THRESH) begin
                    m_thresh = wb_dat_w[7:0];
                end else if (!wb_we && wb_adr == `ET_REG_STATUS) begin
                    m_ready = 1'b0;
                end
            end

            // frame counted 3 cycles after the fall, result after 32
            if (since_fall > 0) begin
                if (since_fall == 3) begin
                    m_frames++;
                end
                if (since_fall == 32) begin
                    m_ready    = 1'b1;
                    m_sum_s    = end_s;
                    m_sum_sx   = end_sx;
                    m_sum_sy   = end_sy;
                    m_point_x  = (end_s == 0) ? '0 : end_sx / end_s;
                    m_point_y  = (end_s == 0) ? '0 : end_sy / end_s;
                    since_fall = 0;
                end else begin
                    since_fall++;
                end
            end

            // ------------------------------
            // pin side
            // ------------------------------
            if (fval && !fval_d) begin
                row    = 0;
                run_s  = '0;
                run_sx = '0;
                run_sy = '0;
            end
            if (lval && !lval_d) begin
                col = 0;
            end
            if (fval && lval && dval) begin
                if (m_enable && data >= m_thresh) begin
                    run_s  = run_s + 1;
                    run_sx = run_sx + wb_data_t'(col);
                    run_sy = run_sy + wb_data_t'(row);
                end
                col++;
            end
            if (!lval && lval_d) begin
                row++;
            end
            if (!fval && fval_d) begin
                end_s      = run_s;
                end_sx     = run_sx;
                end_sy     = run_sy;
                since_fall = 1;
            end
            fval_d = fval;
            lval_d = lval;
        end
    end

endmodule

// File: testbench/tb_eye_tracker.sv
/* Testbench top of the eye tracker. Reads the test frames from the vectors
   file, drives camera frames and Wishbone accesses on the falling clock edge
   and leaves the comparing of every register read to tb_checker. */
`timescale 1ns/1ps
`include "eye_tracker_settings.svh"

module tb_eye_tracker
    import eye_tracker_pkg::*;
();
    localparam int MAX_VECS = 32;
    localparam int LINE_GAP = 2;

    logic     cclk;
    logic     rst;
    logic     fval;
    logic     lval;
    logic     dval;
    pixel_t   data;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    logic [8*16-1:0] test_name;
    int              check_errors;
    int              run_errors;
    logic [31:0]     rng;

    // test frames from the vectors file
    logic [8*16-1:0] vec_name [MAX_VECS];
    int              vec_thresh [MAX_VECS];
    int              vec_enable [MAX_VECS];
    int              vec_level [MAX_VECS];
    int              vec_x0 [MAX_VECS];
    int              vec_y0 [MAX_VECS];
    int              vec_w [MAX_VECS];
    int              vec_h [MAX_VECS];
    int              vec_count;
    logic            vecs_loaded;

    eye_tracker_top dut (
        .cclk     (cclk),
        .rst      (rst),
        .fval     (fval),
        .lval     (lval),
        .dval     (dval),
        .data     (data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    tb_checker u_checker (
        .cclk        (cclk),
        .rst         (rst),
        .fval        (fval),
        .lval        (lval),
        .dval        (dval),
        .data        (data),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .test_name   (test_name),
        .error_count (check_errors)
    );

    bind eye_tracker_top eye_tracker_assertions u_assertions (
        .cclk   (cclk),
        .rst    (rst),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .done_x (done_x),
        .done_y (done_y)
    );

    initial begin
        cclk = 1'b0;
        forever #10 cclk = ~cclk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // blob value inside the rectangle and dark noise below the threshold elsewhere
    function automatic pixel_t pixel_at(input int v, input int col, input int row);
        if (col >= vec_x0[v] && col < vec_x0[v] + vec_w[v] &&
            row >= vec_y0[v] && row < vec_y0[v] + vec_h[v]) begin
            return pixel_t'(vec_level[v]);
        end
        rng = next_random(rng);
        if (vec_thresh[v] == 0) begin
            return '0;
        end
        return pixel_t'(rng % 32'(vec_thresh[v]));
    endfunction

    task automatic load_vectors();
        int              fd;
        int              n;
        string           line;
        logic [8*16-1:0] name;
        int              th;
        int              en;
        int              lv;
        int              x0;
        int              y0;
        int              w;
        int              h;
        vec_count = 0;
        fd = $fopen("testbench/eye_tracker_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/eye_tracker_vectors.txt");
            run_errors++;
            return;
        end
        while (!$feof(fd) && vec_count < MAX_VECS) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s %d %d %d %d %d %d %d", name, th, en, lv, x0, y0, w, h);
                if (n == 8) begin
                    vec_name[vec_count]   = name;
                    vec_thresh[vec_count] = th;
                    vec_enable[vec_count] = en;
                    vec_level[vec_count]  = lv;
                    vec_x0[vec_count]     = x0;
                    vec_y0[vec_count]     = y0;
                    vec_w[vec_count]      = w;
                    vec_h[vec_count]      = h;
                    vec_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // wishbone master
    // ------------------------------
    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge cclk);
        while (!wb_ack && n < 8) begin
            n++;
            @(negedge cclk);
        end
        if (!wb_ack) begin
            $display("no Wishbone ack for an access to address %0d", wb_adr);
            run_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t val);
        @(negedge cclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = val;
        wait_ack();
    endtask

    task automatic read_reg(input wb_addr_t adr, output wb_data_t val);
        @(negedge cclk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        val = wb_dat_r;
    endtask

    // whole map including the unmapped words
    task automatic read_all();
        int       a;
        wb_data_t val;
        for (a = 0; a < 16; a++) begin
            read_reg(wb_addr_t'(a), val);
        end
    endtask

    task automatic poll_result();
        wb_data_t val;
        int       tries;
        tries = 0;
        val   = '0;
        while (val[0] == 1'b0 && tries < 100) begin
            read_reg(`ET_REG_STATUS, val);
            tries++;
        end
        if (val[0] == 1'b0) begin
            $display("result flag never set in test %0s", test_name);
            run_errors++;
        end
    endtask

    // ------------------------------
    // camera frame with one dval gap per line
    // ------------------------------
    task automatic drive_frame(input int v);
        int row;
        int slot;
        int col;
        int drop;
        @(negedge cclk);
        fval = 1'b1;
        for (row = 0; row < `ET_FRAME_H; row++) begin
            repeat (LINE_GAP) begin
                @(negedge cclk);
                lval = 1'b0;
                dval = 1'b0;
                data = '0;
            end
            rng  = next_random(rng);
            drop = int'(rng % 32'd33);
            col  = 0;
            for (slot = 0; slot <= `ET_FRAME_W; slot++) begin
                @(negedge cclk);
                lval = 1'b1;
                if (slot == drop) begin
                    dval = 1'b0;
                    data = 8'hff;
                end else begin
                    dval = 1'b1;
                    data = pixel_at(v, col, row);
                    col++;
                end
            end
        end
        repeat (LINE_GAP) begin
            @(negedge cclk);
            lval = 1'b0;
            dval = 1'b0;
            data = '0;
        end
        @(negedge cclk);
        fval = 1'b0;
    endtask

    initial begin
        int v;
        rst         = 1'b1;
        fval        = 1'b0;
        lval        = 1'b0;
        dval        = 1'b0;
        data        = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        test_name   = "after_reset";
        rng         = 32'd56;
        run_errors  = 0;
        vecs_loaded = 1'b0;
        load_vectors();
        vecs_loaded = 1'b1;
        repeat (10) @(posedge cclk);
        @(negedge cclk);
        rst = 1'b0;

        read_all();

        // read-only and unmapped words ignore writes
        // zero data would show up in control or threshold on a short decode
        test_name = "bus_map";
        write_reg(4'd12, 32'h0000_0000);
        write_reg(4'd9, 32'h0000_0000);
        write_reg(`ET_REG_SUM_S, 32'h0000_1234);
        write_reg(`ET_REG_STATUS, 32'h0000_0001);
        write_reg(`ET_REG_FRAMES, 32'h0000_0005);
        read_all();

        for (v = 0; v < vec_count; v++) begin
            test_name = vec_name[v];
            write_reg(`ET_REG_THRESH, wb_data_t'(vec_thresh[v]));
            write_reg(`ET_REG_CTRL, wb_data_t'(vec_enable[v]));
            drive_frame(v);
            poll_result();
            read_all();
        end

        repeat (4) @(negedge cclk);
        $display("errors: compare %0d, bus and flow %0d, assertion %0d",
                 check_errors, run_errors, dut.u_assertions.fail_count);
        if (check_errors == 0 && run_errors == 0 && vec_count > 0 &&
            dut.u_assertions.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog sized by the number of test frames
    initial begin
        wait (vecs_loaded);
        repeat (vec_count * 1200 + 100) @(posedge cclk);
        $display("watchdog expired after %0d clock periods", vec_count * 1200 + 100);
        $display("Regression failed");
        $finish;
    end

endmodule
